//--- build.f
fpga_wrapper_pkg.sv
reg_block.sv
log_fifo.sv
trng_fifo.sv
trng_throttle.sv
fpga_wrapper_top.sv
fpga_wrapper_sva.sv
tb_checker.sv
tb_fpga_wrapper.sv

//--- Bender.yml
package:
  name: fpga_wrapper

sources:
  - fpga_wrapper_pkg.sv
  - reg_block.sv
  - log_fifo.sv
  - trng_fifo.sv
  - trng_throttle.sv
  - fpga_wrapper_top.sv
  - target: test
    files:
      - fpga_wrapper_sva.sv
      - tb_checker.sv
      - tb_fpga_wrapper.sv

//--- tb_fpga_wrapper.sv
// Testbench top for the FPGA wrapper glue with clock, reset, bus tasks and reference models
`timescale 1ns/1ns

module tb_fpga_wrapper;

    localparam int LOG_DEPTH  = 16;
    localparam int TRNG_DEPTH = 4;
    localparam int TMO        = 500;   // Cycles per wait
    localparam int DIV        = 2;

    logic                       core_clk = 1'b0;
    logic                       hwif_out;
    logic                       req_valid;
    fpga_wrapper_pkg::reg_req_t req;
    logic                       req_ready;
    logic                       rsp_valid;
    fpga_wrapper_pkg::reg_rsp_t rsp;
    logic                       rsp_ready;
    logic                       log_valid;
    fpga_wrapper_pkg::char_t    log_char;
    logic                       log_ready;
    logic                       etrng_req;
    logic                       itrng_valid;
    fpga_wrapper_pkg::nibble_t  itrng_data;

    integer                  seed = 32'h343d86d6;
    fpga_wrapper_pkg::char_t log_q [$];   // Characters in push order
    logic [31:0]             rd;
    logic [31:0]             c1;
    logic [31:0]             word;
    int                      acc;
    int                      t;

    fpga_wrapper_top #(.LOG_DEPTH(LOG_DEPTH), .TRNG_DEPTH(TRNG_DEPTH)) DUT (.*);

    tb_checker chk (.*);

    always #5 core_clk = ~core_clk;

    // Register word seen for a popped log character
    function automatic logic [31:0] log_data_ref(input fpga_wrapper_pkg::char_t c);
        return (32'd1 << fpga_wrapper_pkg::LOG_VALID_BIT) | {24'd0, c};
    endfunction

    function automatic fpga_wrapper_pkg::nibble_t nibble_ref(input logic [31:0] w, input int i);
        return w[4*i +: 4];   // Low nibble first
    endfunction

    task automatic reg_access(input logic [3:0] addr, input logic wr, input logic [31:0] wdata,
                              input logic [31:0] exp, input string name,
                              input logic [31:0] mask = '1, input int hold = 0);
        int          n;
        logic [31:0] held;
        chk.expect_rsp(name, exp, mask);
        req       = '{addr: addr, write: wr, wdata: wdata};
        req_valid = 1'b1;
        n = 0;
        do begin
            @(posedge core_clk);
            n++;
        end while (!req_ready && n < TMO);
        if (!req_ready) chk.report_error({name, ": request was never accepted"});
        #1;
        req_valid = 1'b0;
        rsp_ready = (hold == 0);
        n = 0;
        do begin
            @(posedge core_clk);
            n++;
        end while (!rsp_valid && n < TMO);
        if (!rsp_valid) chk.report_error({name, ": no response arrived"});
        held = rsp.rdata;
        rd   = held;
        if (hold > 0) begin
            // Offer a second request while the response is stalled
            #1;
            req       = '{addr: fpga_wrapper_pkg::VERSION, write: 1'b0, wdata: '0};
            req_valid = 1'b1;
            repeat (hold) begin
                @(posedge core_clk);
                chk.check({name, "_req_ready"}, 32'd0, req_ready);
                chk.check({name, "_rsp_hold"}, held, rsp.rdata);
            end
            #1;
            req_valid = 1'b0;
            rsp_ready = 1'b1;
            @(posedge core_clk);
        end
        #1;
    endtask

    task automatic push_char(input fpga_wrapper_pkg::char_t c);
        int n;
        log_char  = c;
        log_valid = 1'b1;
        n = 0;
        do begin
            @(posedge core_clk);
            n++;
        end while (!log_ready && n < TMO);
        if (!log_ready) chk.report_error("log FIFO never became ready");
        else log_q.push_back(c);
        #1;
        log_valid = 1'b0;
    endtask

    initial begin
        hwif_out  = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b1;
        log_valid = 1'b0;
        log_char  = '0;
        etrng_req = 1'b0;
        repeat (3) @(posedge core_clk);
        #1 hwif_out = 1'b1;
        chk.check("reset_state", 32'b1001, {req_ready, rsp_valid, itrng_valid, log_ready});

        // Version, cycle counter, unmapped address
        reg_access(fpga_wrapper_pkg::VERSION, 1'b0, '0, fpga_wrapper_pkg::FPGA_VERSION, "version");
        reg_access(fpga_wrapper_pkg::CYCLE_COUNT, 1'b0, '0, '0, "cycle_count", '0);
        c1 = rd;
        reg_access(fpga_wrapper_pkg::CYCLE_COUNT, 1'b0, '0, '0, "cycle_count", '0);
        chk.check("cycle_count_increase", 32'd1, rd > c1);
        reg_access(4'hf, 1'b0, '0, '0, "unmapped_read");

        // Log characters come back in push order
        repeat (5) push_char(fpga_wrapper_pkg::char_t'($random(seed)));
        while (log_q.size() != 0) begin
            reg_access(fpga_wrapper_pkg::LOG_DATA, 1'b0, '0, log_data_ref(log_q.pop_front()),
                       "log_data");
        end
        reg_access(fpga_wrapper_pkg::LOG_DATA, 1'b0, '0, '0, "log_data_empty");
        reg_access(fpga_wrapper_pkg::LOG_STATUS, 1'b0, '0,
                   32'd1 << fpga_wrapper_pkg::LOG_STATUS_EMPTY_BIT, "log_status_empty");

        // Overfill the log FIFO
        acc       = 0;
        log_valid = 1'b1;
        repeat (LOG_DEPTH + 2) begin
            log_char = fpga_wrapper_pkg::char_t'($random(seed));
            @(posedge core_clk);
            if (log_ready) begin
                acc++;
                log_q.push_back(log_char);
            end
            #1;
        end
        log_valid = 1'b0;
        chk.check("log_accepted", LOG_DEPTH, acc);
        chk.check("log_ready_full", 32'd0, log_ready);
        reg_access(fpga_wrapper_pkg::LOG_STATUS, 1'b0, '0,
                   32'd1 << fpga_wrapper_pkg::LOG_STATUS_FULL_BIT, "log_status_full");
        while (log_q.size() != 0) begin
            reg_access(fpga_wrapper_pkg::LOG_DATA, 1'b0, '0, log_data_ref(log_q.pop_front()),
                       "log_drain");
        end

        // Throttled entropy stream
        reg_access(fpga_wrapper_pkg::DIVISOR, 1'b1, DIV, '0, "divisor_write");
        reg_access(fpga_wrapper_pkg::DIVISOR, 1'b0, '0, DIV, "divisor_read");
        chk.expect_gap(DIV + 1);
        etrng_req = 1'b1;
        repeat (TRNG_DEPTH) begin
            word = $random(seed);
            for (int i = 0; i < 8; i++) chk.exp_nib.push_back(nibble_ref(word, i));
            reg_access(fpga_wrapper_pkg::ITRNG_DATA, 1'b1, word, '0, "itrng_write");
        end
        t = 0;
        while (chk.exp_nib.size() != 0 && t < 8 * TMO) begin
            @(posedge core_clk);
            t++;
        end
        if (chk.exp_nib.size() != 0) chk.report_error("entropy nibbles did not all arrive");
        #1 etrng_req = 1'b0;
        chk.expect_gap(0);

        // Flush drops the stored word
        reg_access(fpga_wrapper_pkg::ITRNG_DATA, 1'b1, $random(seed), '0, "itrng_write");
        reg_access(fpga_wrapper_pkg::ITRNG_STATUS, 1'b1,
                   32'd1 << fpga_wrapper_pkg::ITRNG_FLUSH_BIT, '0, "itrng_flush");
        etrng_req = 1'b1;
        repeat (10 * (DIV + 1)) @(posedge core_clk);   // Quiet window
        #1 etrng_req = 1'b0;
        reg_access(fpga_wrapper_pkg::ITRNG_STATUS, 1'b0, '0,
                   32'd1 << fpga_wrapper_pkg::ITRNG_STATUS_EMPTY_BIT, "itrng_status_empty");

        // Host stalls the response
        reg_access(fpga_wrapper_pkg::VERSION, 1'b0, '0, fpga_wrapper_pkg::FPGA_VERSION,
                   "rsp_backpressure", '1, 5);

        repeat (5) @(posedge core_clk);
        chk.final_report(DUT.u_sva.fail_count);
        if (chk.errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #200000;
        $display("Simulation watchdog expired before the test sequence finished");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- tb_checker.sv
// Testbench checker comparing bus responses and entropy nibbles with expected values
`timescale 1ns/1ns

module tb_checker (
    input logic                       core_clk,
    input logic                       hwif_out,
    input logic                       rsp_valid,
    input logic                       rsp_ready,
    input fpga_wrapper_pkg::reg_rsp_t rsp,
    input logic                       itrng_valid,
    input fpga_wrapper_pkg::nibble_t  itrng_data
);

    logic [31:0]               exp_data [$];
    logic [31:0]               exp_mask [$];
    string                     exp_name [$];
    fpga_wrapper_pkg::nibble_t exp_nib  [$];

    int checks     = 0;
    int errors     = 0;
    int cycle      = 0;
    int last_pulse = -1;
    int gap        = 0;   // Zero turns the spacing check off

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    task automatic expect_rsp(input string name, input logic [31:0] data,
                              input logic [31:0] mask);
        exp_name.push_back(name);
        exp_data.push_back(data);
        exp_mask.push_back(mask);
    endtask

    task automatic expect_gap(input int cycles);
        gap        = cycles;
        last_pulse = -1;
    endtask

    always @(posedge core_clk) begin : watch
        string       name;
        logic [31:0] mask;
        logic [31:0] data;
        cycle++;
        if (hwif_out && rsp_valid && rsp_ready) begin
            if (exp_data.size() == 0) begin
                report_error("response seen with no request pending");
            end else begin
                name = exp_name.pop_front();
                mask = exp_mask.pop_front();
                data = exp_data.pop_front();
                check(name, data & mask, rsp.rdata & mask);
            end
        end
        if (hwif_out && itrng_valid) begin
            if (exp_nib.size() == 0) begin
                report_error("itrng_valid pulse while no entropy was expected");
            end else begin
                check("itrng_nibble", exp_nib.pop_front(), itrng_data);
            end
            if (gap != 0 && last_pulse >= 0) begin
                check("itrng_spacing", gap, cycle - last_pulse);
            end
            last_pulse = cycle;
        end
    end

    task automatic final_report(input int assert_fails);
        if (exp_data.size() != 0 || exp_nib.size() != 0) begin
            report_error("expected responses or nibbles never arrived");
        end
        errors += assert_fails;
        $display("tb_checker: %0d checks, %0d errors, %0d of them assertion failures",
                 checks, errors, assert_fails);
    endtask

endmodule

//--- fpga_wrapper_sva.sv
// Handshake assertions for the FPGA wrapper top level
`timescale 1ns/1ns

module fpga_wrapper_sva (
    input logic                       core_clk,
    input logic                       hwif_out,
    input logic                       req_valid,
    input logic                       req_ready,
    input logic                       rsp_valid,
    input fpga_wrapper_pkg::reg_rsp_t rsp,
    input logic                       rsp_ready,
    input logic                       itrng_valid
);

    logic pending;   // Accepted request whose response the host has not taken
    int   fail_count = 0;

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            pending <= 1'b0;
        end else if (req_valid && req_ready) begin
            pending <= 1'b1;
        end else if (rsp_valid && rsp_ready) begin
            pending <= 1'b0;
        end
    end

    // Response frozen until the host takes it
    rsp_stable_a: assert property (@(posedge core_clk) disable iff (!hwif_out)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else begin
            fail_count++;
            $error("rsp changed while rsp_ready was low");
        end

    pending_blocks_req_a: assert property (@(posedge core_clk) disable iff (!hwif_out)
        pending |-> rsp_valid && !req_ready)
        else begin
            fail_count++;
            $error("response missing or req_ready high while a request is outstanding");
        end

    itrng_pulse_a: assert property (@(posedge core_clk) disable iff (!hwif_out)
        itrng_valid |=> !itrng_valid)
        else begin
            fail_count++;
            $error("itrng_valid high on two consecutive cycles");
        end

endmodule

bind fpga_wrapper_top fpga_wrapper_sva u_sva (.*);

//--- fpga_wrapper_top.sv
// FPGA wrapper glue top joining the register block, log FIFO, entropy FIFO and throttle
`timescale 1ns/1ns

module fpga_wrapper_top #(
    parameter int LOG_DEPTH  = 16,
    parameter int TRNG_DEPTH = 4   // In words
) (
    input  logic                       core_clk,
    input  logic                       hwif_out,
    input  logic                       req_valid,
    input  fpga_wrapper_pkg::reg_req_t req,
    output logic                       req_ready,
    output logic                       rsp_valid,
    output fpga_wrapper_pkg::reg_rsp_t rsp,
    input  logic                       rsp_ready,
    input  logic                       log_valid,
    input  fpga_wrapper_pkg::char_t    log_char,
    output logic                       log_ready,
    input  logic                       etrng_req,
    output logic                       itrng_valid,
    output fpga_wrapper_pkg::nibble_t  itrng_data
);

    fpga_wrapper_pkg::char_t    log_head;
    fpga_wrapper_pkg::trng_word_u trng_wdata;

    logic        log_empty;
    logic        log_full;
    logic        log_pop;
    logic        trng_push;
    logic        trng_flush;
    logic        trng_empty;
    logic        trng_full;
    logic        grant;
    logic [31:0] divisor;

    reg_block u_reg_block (
        .core_clk, .hwif_out,
        .req_valid, .req, .req_ready,
        .rsp_valid, .rsp, .rsp_ready,
        .log_head, .log_empty, .log_full, .log_pop,
        .trng_push, .trng_wdata, .trng_flush,
        .trng_empty, .trng_full,
        .divisor
    );

    log_fifo #(.LOG_DEPTH(LOG_DEPTH)) u_log_fifo (
        .core_clk, .hwif_out,
        .log_valid, .log_char, .log_ready,
        .log_pop, .log_head, .log_empty, .log_full
    );

    trng_fifo #(.TRNG_DEPTH(TRNG_DEPTH)) u_trng_fifo (
        .core_clk, .hwif_out,
        .trng_push, .trng_wdata, .trng_flush,
        .grant,
        .trng_empty, .trng_full,
        .itrng_valid, .itrng_data
    );

    trng_throttle u_trng_throttle (
        .core_clk, .hwif_out,
        .etrng_req,
        .divisor,
        .grant
    );

endmodule

//--- trng_throttle.sv
// Rate limiter that lets an entropy request through once every divisor+1 cycles
`timescale 1ns/1ns

module trng_throttle (
    input  logic        core_clk,
    input  logic        hwif_out,
    input  logic        etrng_req,
    input  logic [31:0] divisor,
    output logic        grant
);

    logic [31:0] counter;

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            counter <= '0;
            grant   <= 1'b0;
        end else if (counter == '0) begin
            // Window open, sample the request and restart
            grant   <= etrng_req;
            counter <= divisor;
        end else begin
            grant   <= 1'b0;
            counter <= counter - 32'd1;
        end
    end

endmodule

//--- trng_fifo.sv
// Entropy word FIFO that hands out each stored word as eight nibbles, low nibble first
`timescale 1ns/1ns

module trng_fifo #(
    parameter int TRNG_DEPTH = 4
) (
    input  logic                         core_clk,
    input  logic                         hwif_out,
    input  logic                         trng_push,
    input  fpga_wrapper_pkg::trng_word_u trng_wdata,
    input  logic                         trng_flush,
    input  logic                         grant,
    output logic                         trng_empty,
    output logic                         trng_full,
    output logic                         itrng_valid,
    output fpga_wrapper_pkg::nibble_t    itrng_data
);

    localparam int PTR_W = (TRNG_DEPTH > 1) ? $clog2(TRNG_DEPTH) : 1;
    localparam int CNT_W = $clog2(TRNG_DEPTH + 1);

    fpga_wrapper_pkg::trng_word_u mem [TRNG_DEPTH];
    fpga_wrapper_pkg::trng_word_u head_word;

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [2:0]       nib_idx;   // Next nibble of the head word
    logic             push;
    logic             read;
    logic             pop;

    assign trng_empty = (count == '0);
    assign trng_full  = (count == CNT_W'(TRNG_DEPTH));
    assign push       = trng_push & ~trng_full;   // Overflow dropped
    assign read       = grant & ~trng_empty;
    assign pop        = read & (nib_idx == 3'd7); // Last nibble retires the word
    assign head_word  = mem[rd_ptr];

    always_ff @(posedge core_clk) begin
        if (push) begin
            mem[wr_ptr] <= trng_wdata;
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            nib_idx     <= '0;
            itrng_valid <= 1'b0;
            itrng_data  <= '0;
        end else if (trng_flush) begin
            // Drops stored words and any half-read head
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            nib_idx     <= '0;
            itrng_valid <= 1'b0;
        end else begin
            itrng_valid <= read;
            if (read) begin
                itrng_data <= head_word.nib[nib_idx];
                nib_idx    <= nib_idx + 3'd1;  // Wraps to 0 on pop
            end
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(TRNG_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(TRNG_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- log_fifo.sv
// Character log FIFO with first-word fall-through head, drained by register reads
`timescale 1ns/1ns

module log_fifo #(
    parameter int LOG_DEPTH = 16
) (
    input  logic                    core_clk,
    input  logic                    hwif_out,
    input  logic                    log_valid,
    input  fpga_wrapper_pkg::char_t log_char,
    output logic                    log_ready,
    input  logic                    log_pop,
    output fpga_wrapper_pkg::char_t log_head,
    output logic                    log_empty,
    output logic                    log_full
);

    localparam int PTR_W = (LOG_DEPTH > 1) ? $clog2(LOG_DEPTH) : 1;
    localparam int CNT_W = $clog2(LOG_DEPTH + 1);

    fpga_wrapper_pkg::char_t mem [LOG_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign log_empty = (count == '0);
    assign log_full  = (count == CNT_W'(LOG_DEPTH));
    assign log_ready = ~log_full;
    assign push      = log_valid & log_ready;
    assign pop       = log_pop & ~log_empty;
    assign log_head  = mem[rd_ptr];  // Fall-through head

    always_ff @(posedge core_clk) begin
        if (push) begin
            mem[wr_ptr] <= log_char;
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(LOG_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(LOG_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- reg_block.sv
// Host register block with cycle counter, divisor register and one-deep response handshake
`timescale 1ns/1ns

module reg_block (
    input  logic                         core_clk,
    input  logic                         hwif_out,
    input  logic                         req_valid,
    input  fpga_wrapper_pkg::reg_req_t   req,
    output logic                         req_ready,
    output logic                         rsp_valid,
    output fpga_wrapper_pkg::reg_rsp_t   rsp,
    input  logic                         rsp_ready,
    input  fpga_wrapper_pkg::char_t      log_head,
    input  logic                         log_empty,
    input  logic                         log_full,
    output logic                         log_pop,
    output logic                         trng_push,
    output fpga_wrapper_pkg::trng_word_u trng_wdata,
    output logic                         trng_flush,
    input  logic                         trng_empty,
    input  logic                         trng_full,
    output logic [31:0]                  divisor
);

    logic        accept;
    logic        rd_accept;
    logic        wr_accept;
    logic [31:0] cycle_count;
    logic [31:0] rdata;

    assign req_ready = ~rsp_valid;  // Single outstanding request
    assign accept    = req_valid & req_ready;
    assign rd_accept = accept & ~req.write;
    assign wr_accept = accept & req.write;

    // Side effects of accepted requests
    assign log_pop    = rd_accept & (req.addr == fpga_wrapper_pkg::LOG_DATA) & ~log_empty;
    assign trng_push  = wr_accept & (req.addr == fpga_wrapper_pkg::ITRNG_DATA);
    assign trng_wdata = req.wdata;
    assign trng_flush = wr_accept & (req.addr == fpga_wrapper_pkg::ITRNG_STATUS)
                        & req.wdata[fpga_wrapper_pkg::ITRNG_FLUSH_BIT];

    // Read mux, sampled at acceptance
    always_comb begin
        rdata = '0;
        case (req.addr)
            fpga_wrapper_pkg::VERSION:     rdata = fpga_wrapper_pkg::FPGA_VERSION;
            fpga_wrapper_pkg::CYCLE_COUNT: rdata = cycle_count;
            fpga_wrapper_pkg::DIVISOR:     rdata = divisor;
            fpga_wrapper_pkg::LOG_DATA: begin
                if (!log_empty) begin
                    rdata[7:0]                             = log_head;
                    rdata[fpga_wrapper_pkg::LOG_VALID_BIT] = 1'b1;
                end
            end
            fpga_wrapper_pkg::LOG_STATUS: begin
                rdata[fpga_wrapper_pkg::LOG_STATUS_EMPTY_BIT] = log_empty;
                rdata[fpga_wrapper_pkg::LOG_STATUS_FULL_BIT]  = log_full;
            end
            fpga_wrapper_pkg::ITRNG_STATUS: begin
                rdata[fpga_wrapper_pkg::ITRNG_STATUS_EMPTY_BIT] = trng_empty;
                rdata[fpga_wrapper_pkg::ITRNG_STATUS_FULL_BIT]  = trng_full;
            end
            default: rdata = '0;  // ITRNG_DATA is write only, rest unmapped
        endcase
    end

    // Pending response
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            rsp_valid <= 1'b0;
            rsp       <= '0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
            rsp.rdata <= req.write ? 32'd0 : rdata;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            divisor <= '0;
        end else if (wr_accept && req.addr == fpga_wrapper_pkg::DIVISOR) begin
            divisor <= req.wdata;
        end
    end

    // Free running, wraps
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 32'd1;
        end
    end

endmodule

//--- fpga_wrapper_pkg.sv
// Shared register map, bus structs and entropy word types for the FPGA wrapper glue
package fpga_wrapper_pkg;

    localparam logic [31:0] FPGA_VERSION = 32'h0002_0107;

    localparam int ADDR_W = 4;

    // Register word addresses
    typedef enum logic [ADDR_W-1:0] {
        VERSION      = 4'd0,
        CYCLE_COUNT  = 4'd1,
        DIVISOR      = 4'd2,
        LOG_DATA     = 4'd3,
        LOG_STATUS   = 4'd4,
        ITRNG_DATA   = 4'd5,
        ITRNG_STATUS = 4'd6
    } reg_addr_e;

    // Bit positions inside data and status words
    localparam int LOG_VALID_BIT          = 8;  // Above the character
    localparam int LOG_STATUS_EMPTY_BIT   = 0;
    localparam int LOG_STATUS_FULL_BIT    = 1;
    localparam int ITRNG_STATUS_EMPTY_BIT = 0;
    localparam int ITRNG_STATUS_FULL_BIT  = 1;
    localparam int ITRNG_FLUSH_BIT        = 2;  // Write only

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              write;
        logic [31:0]       wdata;
    } reg_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } reg_rsp_t;

    typedef logic [7:0] char_t;
    typedef logic [3:0] nibble_t;

    // Written as a word, consumed as nibbles
    typedef union packed {
        logic [31:0]      word;
        nibble_t [7:0]    nib;   // nib[0] is the low nibble
    } trng_word_u;

endpackage
